// File: rtl/card_list_config.svh
`ifndef CARD_LIST_CONFIG_SVH
`define CARD_LIST_CONFIG_SVH

// Node address width where address zero is the null link
`define CARD_ADDR_W 10

// One node per RAM word
`define CARD_DEPTH 1024

`define CARD_WORD_W 32

// Card fields
`define CARD_VALUE_W 4
`define CARD_SUIT_W 2

// Removal index counted in links from the head
`define CARD_N_W 6

`endif

// File: rtl/card_list_pkg.sv
`include "card_list_config.svh"

package card_list_pkg;

    typedef struct packed {
        logic [`CARD_SUIT_W-1:0]  suit;
        logic [`CARD_VALUE_W-1:0] value;
    } card_t;

    // One RAM word holding a list node
    typedef struct packed {
        logic                    used;    // Word holds a live card
        logic [8:0]              pad_hi;
        card_t                   card;
        logic [5:0]              pad_lo;
        logic [`CARD_ADDR_W-1:0] next;    // Zero ends the list
    } card_node_t;

    typedef struct packed {
        logic [`CARD_ADDR_W-1:0] address;
        logic                    write;
        card_node_t              data;
    } ram_req_t;

endpackage

// File: rtl/card_ram.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module card_ram (
    input  logic                      clock,
    input  logic                      reset,
    input  card_list_pkg::ram_req_t   req,
    output card_list_pkg::card_node_t q
);

    logic [`CARD_WORD_W-1:0] mem [`CARD_DEPTH];
    logic [`CARD_DEPTH-1:0]  valid;     // Word written since reset
    logic [`CARD_WORD_W-1:0] rdata;
    logic                    rd_valid;

    // Read-first port shows the old word during a write
    always_ff @(posedge clock) begin
        if (req.write) begin
            mem[req.address] <= req.data;
        end
        rdata <= mem[req.address];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid[req.address];
            if (req.write) begin
                valid[req.address] <= 1'b1;
            end
        end
    end

    // Never-written words read as an empty node
    assign q = rd_valid ? card_list_pkg::card_node_t'(rdata) : '0;

endmodule

// File: rtl/node_allocator.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module node_allocator (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      alloc_start,
    output card_list_pkg::ram_req_t   req,
    input  card_list_pkg::card_node_t q,
    output logic                      alloc_done,
    output logic                      alloc_full,
    output logic [`CARD_ADDR_W-1:0]   alloc_addr
);

    localparam int LAST_ADDR = `CARD_DEPTH - 1;
    localparam logic [`CARD_ADDR_W-1:0] FIRST_ADDR = {{(`CARD_ADDR_W-1){1'b0}}, 1'b1};

    logic                    scanning;
    logic [`CARD_ADDR_W-1:0] scan_addr;    // Address being read this cycle
    logic [`CARD_ADDR_W-1:0] check_addr;   // Address whose word is on q
    logic                    last;

    assign last = (check_addr == LAST_ADDR[`CARD_ADDR_W-1:0]);

    // Stop on the first unused word or after the top address
    assign alloc_done = scanning && (!q.used || last);
    assign alloc_full = q.used;
    assign alloc_addr = check_addr;

    // Never writes and sends address 1 with the start pulse
    always_comb begin
        req         = '0;
        req.address = alloc_start ? FIRST_ADDR : scan_addr;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            scanning <= 1'b0;
        end else if (alloc_start) begin
            scanning <= 1'b1;
        end else if (alloc_done) begin
            scanning <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_start) begin
            check_addr <= FIRST_ADDR;
            scan_addr  <= FIRST_ADDR + 1'b1;
        end else if (scanning) begin
            check_addr <= scan_addr;
            scan_addr  <= scan_addr + 1'b1;   // Wrapped address is never checked
        end
    end

endmodule

// File: rtl/add_card_unit.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module add_card_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic [`CARD_ADDR_W-1:0]   head,
    input  card_list_pkg::card_t      card_in,
    output card_list_pkg::ram_req_t   req,
    input  card_list_pkg::card_node_t q,
    output logic                      alloc_start,
    input  logic                      alloc_done,
    input  logic                      alloc_full,
    input  logic [`CARD_ADDR_W-1:0]   alloc_addr,
    output logic                      done,
    output logic                      error,
    output logic [`CARD_ADDR_W-1:0]   node_addr
);

    typedef enum logic [2:0] {
        IDLE,
        WALK,
        ALLOC_REQ,
        ALLOC_WAIT,
        WRITE_NODE,
        WRITE_LINK
    } state_t;

    state_t                    state;
    logic                      q_valid;    // q holds the word at cur_addr
    logic [`CARD_ADDR_W-1:0]   cur_addr;   // Ends up as the tail address
    logic                      has_tail;   // List was not empty
    card_list_pkg::card_t      card_r;
    card_list_pkg::card_node_t tail_word;
    logic [`CARD_ADDR_W-1:0]   new_addr;

    assign alloc_start = (state == ALLOC_REQ);
    assign node_addr   = new_addr;

    always_comb begin
        req = '0;
        case (state)
            WALK: begin
                req.address = q_valid ? q.next : cur_addr;   // Read ahead on the link
            end
            WRITE_NODE: begin
                req.address   = new_addr;
                req.write     = 1'b1;
                req.data.used = 1'b1;
                req.data.card = card_r;
            end
            WRITE_LINK: begin
                req.address   = cur_addr;
                req.write     = 1'b1;
                req.data      = tail_word;
                req.data.next = new_addr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            q_valid <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        q_valid <= 1'b0;
                        state   <= (head == '0) ? ALLOC_REQ : WALK;   // Empty list
                    end
                end
                WALK: begin
                    q_valid <= 1'b1;
                    if (q_valid && q.next == '0) begin
                        state <= ALLOC_REQ;
                    end
                end
                ALLOC_REQ: state <= ALLOC_WAIT;
                ALLOC_WAIT: begin
                    if (alloc_done) begin
                        if (alloc_full) begin
                            done  <= 1'b1;
                            error <= 1'b1;
                            state <= IDLE;
                        end else begin
                            state <= WRITE_NODE;
                        end
                    end
                end
                WRITE_NODE: begin
                    if (has_tail) begin
                        state <= WRITE_LINK;
                    end else begin
                        done  <= 1'b1;
                        error <= 1'b0;
                        state <= IDLE;
                    end
                end
                WRITE_LINK: begin
                    done  <= 1'b1;
                    error <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            IDLE: begin
                if (start) begin
                    cur_addr <= head;
                    card_r   <= card_in;
                    has_tail <= (head != '0);
                end
            end
            WALK: begin
                if (q_valid) begin
                    if (q.next == '0) begin
                        tail_word <= q;
                    end else begin
                        cur_addr <= q.next;
                    end
                end
            end
            ALLOC_WAIT: begin
                if (alloc_done) begin
                    new_addr <= alloc_full ? '0 : alloc_addr;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/remove_card_unit.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module remove_card_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic [`CARD_ADDR_W-1:0]   head,
    input  logic [`CARD_N_W-1:0]      n,
    output card_list_pkg::ram_req_t   req,
    input  card_list_pkg::card_node_t q,
    output logic                      done,
    output logic                      error,
    output card_list_pkg::card_t      removed_card
);

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        WRITE_PRED,
        CLEAR
    } state_t;

    state_t                    state;
    logic                      q_valid;     // q holds the word at cur_addr
    logic [`CARD_ADDR_W-1:0]   cur_addr;    // Ends up as the target address
    logic [`CARD_N_W-1:0]      n_r;
    logic [`CARD_N_W-1:0]      count;       // Links followed to reach cur_addr
    logic [`CARD_ADDR_W-1:0]   pred_addr;
    card_list_pkg::card_node_t pred_word;
    card_list_pkg::card_node_t tgt_word;
    logic                      start_error;
    logic                      at_target;
    logic                      walk_error;

    // n of zero would remove the head, which has no predecessor
    assign start_error = (head == '0) || (n == '0);
    assign at_target   = q_valid && (count == n_r);
    assign walk_error  = q_valid && (count != n_r) && (q.next == '0);

    always_comb begin
        req = '0;
        case (state)
            WALK: req.address = q_valid ? q.next : cur_addr;
            WRITE_PRED: begin
                req.address   = pred_addr;
                req.write     = 1'b1;
                req.data      = pred_word;
                req.data.next = tgt_word.next;   // Skip over the removed node
            end
            CLEAR: begin
                req.address = cur_addr;
                req.write   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            q_valid <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && start_error) begin
                        done  <= 1'b1;
                        error <= 1'b1;
                    end else if (start) begin
                        q_valid <= 1'b0;
                        state   <= WALK;
                    end
                end
                WALK: begin
                    q_valid <= 1'b1;
                    if (at_target) begin
                        state <= WRITE_PRED;
                    end else if (walk_error) begin
                        done  <= 1'b1;   // Ran off the tail
                        error <= 1'b1;
                        state <= IDLE;
                    end
                end
                WRITE_PRED: state <= CLEAR;
                CLEAR: begin
                    done  <= 1'b1;
                    error <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            IDLE: begin
                if (start) begin
                    cur_addr <= head;
                    n_r      <= n;
                    count    <= '0;
                    if (start_error) begin
                        removed_card <= '0;
                    end
                end
            end
            WALK: begin
                if (at_target) begin
                    tgt_word <= q;
                end else if (walk_error) begin
                    removed_card <= '0;
                end else if (q_valid) begin
                    pred_addr <= cur_addr;
                    pred_word <= q;
                    cur_addr  <= q.next;
                    count     <= count + 1'b1;
                end
            end
            CLEAR: removed_card <= tgt_word.card;
            default: ;
        endcase
    end

endmodule

// File: rtl/card_list_top.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module card_list_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    add_start,
    input  logic                    remove_start,
    input  logic [`CARD_ADDR_W-1:0] head,
    input  card_list_pkg::card_t    card_in,
    input  logic [`CARD_N_W-1:0]    n,
    output logic                    done,
    output logic                    error,
    output logic                    busy,
    output logic [`CARD_ADDR_W-1:0] node_addr,
    output card_list_pkg::card_t    removed_card
);

    card_list_pkg::ram_req_t   add_req;
    card_list_pkg::ram_req_t   rem_req;
    card_list_pkg::ram_req_t   alloc_req;
    card_list_pkg::ram_req_t   ram_req;
    card_list_pkg::card_node_t q;

    logic                    add_go;
    logic                    rem_go;
    logic                    op_add;       // Running command is an add
    logic                    alloc_busy;   // Allocator owns the RAM
    logic                    alloc_start;
    logic                    alloc_done;
    logic                    alloc_full;
    logic [`CARD_ADDR_W-1:0] alloc_addr;
    logic                    add_done;
    logic                    add_error;
    logic [`CARD_ADDR_W-1:0] add_node_addr;
    logic                    rem_done;
    logic                    rem_error;
    card_list_pkg::card_t    rem_card;

    assign add_go = !busy && add_start;                    // Add wins a tie
    assign rem_go = !busy && !add_start && remove_start;

    always_comb begin
        if (busy && op_add) begin
            ram_req = (alloc_start || alloc_busy) ? alloc_req : add_req;
        end else begin
            ram_req = rem_req;   // Idle remove unit never writes
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy         <= 1'b0;
            op_add       <= 1'b0;
            alloc_busy   <= 1'b0;
            done         <= 1'b0;
            error        <= 1'b0;
            node_addr    <= '0;
            removed_card <= '0;
        end else begin
            done <= add_done || rem_done;
            if (add_go || rem_go) begin
                busy   <= 1'b1;
                op_add <= add_go;
            end else if (add_done || rem_done) begin
                busy <= 1'b0;
            end
            if (alloc_start) begin
                alloc_busy <= 1'b1;
            end else if (alloc_done) begin
                alloc_busy <= 1'b0;
            end
            if (add_done) begin
                error     <= add_error;
                node_addr <= add_node_addr;
            end
            if (rem_done) begin
                error        <= rem_error;
                removed_card <= rem_card;
            end
        end
    end

    card_ram u_ram (
        .clock (clock),
        .reset (reset),
        .req   (ram_req),
        .q     (q)
    );

    node_allocator u_alloc (
        .clock       (clock),
        .reset       (reset),
        .alloc_start (alloc_start),
        .req         (alloc_req),
        .q           (q),
        .alloc_done  (alloc_done),
        .alloc_full  (alloc_full),
        .alloc_addr  (alloc_addr)
    );

    add_card_unit u_add (
        .clock       (clock),
        .reset       (reset),
        .start       (add_go),
        .head        (head),
        .card_in     (card_in),
        .req         (add_req),
        .q           (q),
        .alloc_start (alloc_start),
        .alloc_done  (alloc_done),
        .alloc_full  (alloc_full),
        .alloc_addr  (alloc_addr),
        .done        (add_done),
        .error       (add_error),
        .node_addr   (add_node_addr)
    );

    remove_card_unit u_remove (
        .clock        (clock),
        .reset        (reset),
        .start        (rem_go),
        .head         (head),
        .n            (n),
        .req          (rem_req),
        .q            (q),
        .done         (rem_done),
        .error        (rem_error),
        .removed_card (rem_card)
    );

endmodule

// File: test/card_list_tb.sv
`timescale 1ns/1ps
`include "card_list_config.svh"

module card_list_tb;

    localparam int TIMEOUT_CYCLES = 4000;   // Covers a full allocator scan
    localparam int MAX_LEN        = 64;

    localparam logic       OP_ADD = 1'b1;
    localparam logic       OP_REM = 1'b0;
    localparam logic [1:0] SEL_A  = 2'd0;
    localparam logic [1:0] SEL_B  = 2'd1;
    localparam logic [1:0] NEW_A  = 2'd2;   // New list A from head zero
    localparam logic [1:0] NEW_B  = 2'd3;

    typedef struct packed {
        logic                 is_add;
        logic [1:0]           sel;
        card_list_pkg::card_t card;
        logic [`CARD_N_W-1:0] n;
        logic                 stray;       // Second start pulse while busy
        logic                 exp_error;
    } entry_t;

    logic                    clock;
    logic                    reset;
    logic                    add_start;
    logic                    remove_start;
    logic [`CARD_ADDR_W-1:0] head;
    card_list_pkg::card_t    card_in;
    logic [`CARD_N_W-1:0]    n;
    logic                    done;
    logic                    error;
    logic                    busy;
    logic [`CARD_ADDR_W-1:0] node_addr;
    card_list_pkg::card_t    removed_card;

    entry_t stim [$];

    // Model of RAM occupancy and of the two lists with the head card at index 0
    logic [`CARD_DEPTH-1:0]  used_map;
    logic [`CARD_ADDR_W-1:0] list_addr [2][MAX_LEN];
    card_list_pkg::card_t    list_card [2][MAX_LEN];
    int                      list_len  [2];

    card_list_top dut (
        .clock        (clock),
        .reset        (reset),
        .add_start    (add_start),
        .remove_start (remove_start),
        .head         (head),
        .card_in      (card_in),
        .n            (n),
        .done         (done),
        .error        (error),
        .busy         (busy),
        .node_addr    (node_addr),
        .removed_card (removed_card)
    );

    always #5 clock = ~clock;

    function automatic card_list_pkg::card_t make_card(input int suit, input int value);
        card_list_pkg::card_t c;
        c.suit  = suit[`CARD_SUIT_W-1:0];
        c.value = value[`CARD_VALUE_W-1:0];
        return c;
    endfunction

    function automatic entry_t make_entry(input logic is_add, input logic [1:0] sel,
                                          input card_list_pkg::card_t card, input int n_val,
                                          input logic stray, input logic exp_error);
        entry_t e;
        e.is_add    = is_add;
        e.sel       = sel;
        e.card      = card;
        e.n         = n_val[`CARD_N_W-1:0];
        e.stray     = stray;
        e.exp_error = exp_error;
        return e;
    endfunction

    // Lowest address from 1 with no live card
    function automatic logic [`CARD_ADDR_W-1:0] lowest_free();
        int a;
        for (a = 1; a < `CARD_DEPTH; a++) begin
            if (!used_map[a]) begin
                return a[`CARD_ADDR_W-1:0];
            end
        end
        return '0;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic wait_done(input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timeout: no done pulse for entry %0d", idx));
            end
        end while (done !== 1'b1);
    endtask

    task automatic load_table();
        stim.push_back(make_entry(OP_ADD, NEW_A, make_card(0, 1), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(0, 2), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(1, 3), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(2, 4), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, NEW_B, make_card(3, 9), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_B, make_card(3, 10), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(1, 5), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_B, make_card(2, 11), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 1, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_B, make_card(0, 12), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 2, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 5, 1'b0, 1'b1));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 2, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_B, make_card(0, 0), 1, 1'b1, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(2, 6), 0, 1'b1, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_B, make_card(0, 0), 1, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_B, make_card(0, 0), 1, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_B, make_card(0, 0), 1, 1'b0, 1'b1));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 0, 1'b0, 1'b1));
        stim.push_back(make_entry(OP_ADD, SEL_B, make_card(1, 7), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_B, make_card(3, 13), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(0, 8), 0, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 3, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 3, 1'b0, 1'b1));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 1, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_A, make_card(0, 0), 1, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_REM, SEL_B, make_card(0, 0), 2, 1'b0, 1'b0));
        stim.push_back(make_entry(OP_ADD, SEL_A, make_card(2, 14), 0, 1'b0, 1'b0));
    endtask

    task automatic apply_entry(input int idx);
        entry_t                  e;
        int                      li;
        int                      k;
        int                      j;
        logic [`CARD_ADDR_W-1:0] exp_addr;
        e  = stim[idx];
        li = int'(e.sel[0]);
        @(posedge clock);
        head    <= e.sel[1] ? '0 : list_addr[li][0];
        card_in <= e.card;
        n       <= e.n;
        if (e.is_add) begin
            add_start <= 1'b1;
        end else begin
            remove_start <= 1'b1;
        end
        @(posedge clock);
        if (e.stray) begin
            add_start    <= !e.is_add;   // Other command that must be dropped
            remove_start <= e.is_add;
            card_in      <= card_list_pkg::card_t'(~e.card);
            n            <= e.n + 1'b1;
        end else begin
            add_start    <= 1'b0;
            remove_start <= 1'b0;
        end
        @(negedge clock);
        check_value("busy", 32'(busy), 32'd1);
        if (e.stray) begin
            @(posedge clock);
            add_start    <= 1'b0;
            remove_start <= 1'b0;
        end
        wait_done(idx);
        check_value("busy", 32'(busy), 32'd0);
        check_value("error", 32'(error), 32'(e.exp_error));
        if (!e.exp_error && e.is_add) begin
            exp_addr = lowest_free();
            check_value("node_addr", 32'(node_addr), 32'(exp_addr));
            used_map[exp_addr] = 1'b1;
            if (e.sel[1]) begin
                list_len[li] = 0;
            end
            list_addr[li][list_len[li]] = exp_addr;
            list_card[li][list_len[li]] = e.card;
            list_len[li]++;
        end else if (!e.exp_error) begin
            k = int'(e.n);
            check_value("removed_card", 32'(removed_card), 32'(list_card[li][k]));
            used_map[list_addr[li][k]] = 1'b0;
            for (j = k; j < list_len[li] - 1; j++) begin
                list_addr[li][j] = list_addr[li][j + 1];
                list_card[li][j] = list_card[li][j + 1];
            end
            list_len[li]--;
        end
        // No second done from the dropped start
        repeat (e.stray ? 8 : 1) begin
            @(negedge clock);
            check_value("done", 32'(done), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
        end
    endtask

    initial begin
        int i;
        clock        = 1'b0;
        reset        = 1'b1;
        add_start    = 1'b0;
        remove_start = 1'b0;
        head         = '0;
        card_in      = '0;
        n            = '0;
        used_map     = '0;
        list_len[0]  = 0;
        list_len[1]  = 0;
        void'($urandom(57));
        load_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("error", 32'(error), 32'd0);
        check_value("node_addr", 32'(node_addr), 32'd0);
        check_value("removed_card", 32'(removed_card), 32'd0);
        for (i = 0; i < stim.size(); i++) begin
            repeat ($urandom % 4) @(posedge clock);   // Idle gap
            apply_entry(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: card_list.f
+incdir+rtl
rtl/card_list_pkg.sv
rtl/card_ram.sv
rtl/node_allocator.sv
rtl/add_card_unit.sv
rtl/remove_card_unit.sv
rtl/card_list_top.sv
test/card_list_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       ?= card_list_tb
FILELIST  ?= card_list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
